// File: sim.f
+incdir+source
source/obj_pkg.sv
source/obj_tbl_if.sv
source/obj_table.sv
source/obj_scan.sv
source/obj_draw.sv
source/obj_top.sv
bench/obj_tb.sv

// File: Bender.yml
package:
  name: obj_line_engine

export_include_dirs:
  - source

sources:
  - files:
      - source/obj_pkg.sv
      - source/obj_tbl_if.sv
      - source/obj_table.sv
      - source/obj_scan.sv
      - source/obj_draw.sv
      - source/obj_top.sv
  - target: test
    files:
      - bench/obj_tb.sv

// File: bench/obj_tb.sv
// Line end is seen as walker idle with drawer drained; ROM pattern hashes the whole address
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_tb;

    localparam int ACCESS_CYC = 8;                           // Four-phase access under contention
    localparam int LINE_CYC   = 256 * (6 * ACCESS_CYC + 24); // Worst walk plus draw per object
    localparam int TIMEOUT_NS = (64 * LINE_CYC + 4096) * 4;  // 64 lines plus setup margin
    localparam int N_RW       = 24;                          // Random table words

    logic                   clk;
    logic                   rst;
    logic                   hstart;
    logic [8:0]             vrender;
    logic                   host_req;
    logic                   host_ack;
    logic                   host_we;
    logic [`OBJ_TBL_AW-1:0] host_addr;
    logic [15:0]            host_wdata;
    logic [15:0]            host_rdata;
    logic [17:0]            rom_addr;
    logic [15:0]            rom_data;
    logic                   buf_we;
    logic [8:0]             buf_addr;
    logic [11:0]            buf_data;

    logic [15:0] shadow [2**`OBJ_TBL_AW];  // What the table should hold
    logic [20:0] exp_q [$];                // Expected {addr, data} writes
    logic [20:0] act_q [$];                // Seen writes
    logic [31:0] rng;
    string       test_name;

    obj_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .hstart     (hstart),
        .vrender    (vrender),
        .host_req   (host_req),
        .host_ack   (host_ack),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .buf_we     (buf_we),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sprite ROM contents, about a quarter of nibbles forced clear
    function automatic logic [15:0] rom_pattern(input logic [17:0] a);
        logic [31:0] h;
        logic [15:0] d;
        h = xorshift32(xorshift32(32'h1057_18c3 ^ {14'd0, a}));
        d = h[15:0];
        for (int j = 0; j < 4; j++) begin
            if (h[16+2*j +: 2] == 2'b00) d[4*j +: 4] = 4'h0;
        end
        return d;
    endfunction

    // Bottom in high byte, top in low byte
    function automatic logic [15:0] zone_of(input int o);
        case (o)
            0:       return 16'h1E14;  // 20..29
            1:       return 16'h2816;  // Starts on line 22
            2:       return 16'h1A14;
            3:       return 16'h1519;  // Top not below bottom
            4:       return 16'h7864;  // Never hit
            5:       return 16'h1813;  // Top before first scanned line
            6:       return 16'hC80A;
            7:       return 16'hEF00;  // Nearly full screen
            8:       return 16'hF000;  // End marker
            default: return 16'h1E14;  // Hidden behind marker
        endcase
    endfunction

    // ROM answers one clock after the address
    always @(posedge clk) rom_data <= #1 rom_pattern(rom_addr);

    // Line buffer writes
    always @(negedge clk) begin
        if (buf_we === 1'b1) act_q.push_back({buf_addr, buf_data});
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    // Hang guard
    initial begin
        #(TIMEOUT_NS);
        abort_run("timeout, the run did not finish in the expected time");
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One four-phase host access
    task automatic host_access(input logic we, input logic [`OBJ_TBL_AW-1:0] addr,
                               input logic [15:0] wdata, output logic [15:0] rdata);
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        host_req   = 1'b1;
        do next_cycle(); while (host_ack !== 1'b1);
        rdata    = host_rdata;
        host_req = 1'b0;           // Phase 3
        do next_cycle(); while (host_ack !== 1'b0);
    endtask

    task automatic write_word(input int addr, input logic [15:0] data);
        logic [15:0] unused;
        host_access(1'b1, `OBJ_TBL_AW'(addr), data, unused);
        shadow[addr] = data;
    endtask

    task automatic table_rw();
        logic [`OBJ_TBL_AW-1:0] addrs [N_RW];
        logic [15:0]            rd;
        for (int i = 0; i < N_RW; i++) begin
            rng      = xorshift32(rng);
            addrs[i] = rng[`OBJ_TBL_AW-1:0];
            write_word(addrs[i], rng[31:16]);
        end
        for (int i = 0; i < N_RW; i++) begin
            host_access(1'b0, addrs[i], 16'h0, rd);
            assert (rd == shadow[addrs[i]]) else abort_run($sformatf(
                "mismatch %s expected %h actual %h", test_name, shadow[addrs[i]], rd));
        end
    endtask

    // Ten descriptors, the last one after the end marker
    task automatic setup_objects();
        int base;
        for (int o = 0; o < 10; o++) begin
            base = o * `OBJ_WORDS_PER_ENTRY;
            write_word(base + `OBJ_W_ZONE, zone_of(o));
            rng = xorshift32(rng);
            if (o == 1) write_word(base + `OBJ_W_XPOS, 16'd505);       // Wraps past 511
            else if (o == 6) write_word(base + `OBJ_W_XPOS, 16'd510);
            else write_word(base + `OBJ_W_XPOS, {7'd0, rng[8:0]});
            write_word(base + `OBJ_W_PITCH, rng[31:16]);
            rng = xorshift32(rng);
            write_word(base + `OBJ_W_OFFSET, {o[0], rng[14:0]});        // Odd ones flipped
            write_word(base + `OBJ_W_ATTR, rng[31:16] & 16'h3F73);
            rng = xorshift32(rng);
            write_word(base + `OBJ_W_RUN, rng[15:0]);
        end
    endtask

    // Expected writes of one line, advancing shadow RUN words
    task automatic model_line(input int line);
        logic [15:0] z;
        logic [15:0] ofs;
        logic [15:0] attr;
        logic [15:0] data;
        logic [14:0] w;
        logic [3:0]  p;
        logic [8:0]  x;
        int          base;
        bit          stop;
        exp_q.delete();
        if (line > `OBJ_LAST_LINE) return;
        stop = 1'b0;
        for (int o = 0; o < 256 && !stop; o++) begin
            base = o * `OBJ_WORDS_PER_ENTRY;
            z    = shadow[base + `OBJ_W_ZONE];
            if (z[15:8] >= `OBJ_END_MARK) begin
                stop = 1'b1;
            end else if (z[7:0] < z[15:8] && line >= z[7:0] && line < z[15:8]) begin
                ofs  = (line == z[7:0]) ? shadow[base + `OBJ_W_OFFSET]
                                        : shadow[base + `OBJ_W_RUN];
                shadow[base + `OBJ_W_RUN] = ofs + shadow[base + `OBJ_W_PITCH];
                x    = shadow[base + `OBJ_W_XPOS][8:0];
                attr = shadow[base + `OBJ_W_ATTR];
                for (int k = 0; k < `OBJ_DRAW_WORDS; k++) begin
                    w    = ofs[15] ? ofs[14:0] - 15'(k) : ofs[14:0] + 15'(k);
                    data = rom_pattern({attr[6:4], w});
                    for (int j = 0; j < 4; j++) begin
                        p = ofs[15] ? data[4*j +: 4] : data[15-4*j -: 4];
                        if (p != 4'h0) begin
                            exp_q.push_back({9'(x + 4*k + j), attr[1:0], attr[13:8], p});
                        end
                    end
                end
            end
        end
    endtask

    // Walker idle and drawer drained
    task automatic wait_idle();
        do next_cycle(); while (!(int'(i_dut.i_scan.st) == 0 && i_dut.i_draw.busy == 1'b0));
    endtask

    // Reads of non-RUN words that race the walker
    task automatic host_reads(input int n);
        logic [15:0]            rd;
        logic [`OBJ_TBL_AW-1:0] a;
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            a   = `OBJ_TBL_AW'((rng[7:0] % 10) * `OBJ_WORDS_PER_ENTRY + rng[15:8] % 5);
            host_access(1'b0, a, 16'h0, rd);
            assert (rd == shadow[a]) else abort_run($sformatf(
                "mismatch host_during_scan expected %h actual %h", shadow[a], rd));
        end
    endtask

    // Order free match of the two write sets
    task automatic compare_writes();
        bit found;
        assert (act_q.size() == exp_q.size()) else abort_run($sformatf(
            "mismatch %s expected %0d writes actual %0d", test_name, exp_q.size(), act_q.size()));
        foreach (exp_q[e]) begin
            found = 1'b0;
            for (int i = 0; i < act_q.size() && !found; i++) begin
                if (act_q[i] == exp_q[e]) begin
                    act_q.delete(i);
                    found = 1'b1;
                end
            end
            assert (found) else abort_run($sformatf(
                "mismatch %s expected %h actual none", test_name, exp_q[e]));
        end
    endtask

    task automatic run_line(input int line, input bit busy_host);
        test_name = $sformatf("line_%0d", line);
        model_line(line);
        act_q.delete();
        vrender = 9'(line);
        hstart  = 1'b1;
        next_cycle();
        hstart  = 1'b0;
        fork
            wait_idle();
            if (busy_host) host_reads(8);
        join
        next_cycle();  // Last pixel is caught on the negedge before this
        compare_writes();
        next_cycle();
    endtask

    // RUN after k lines from the first one at top
    task automatic check_run(input int o, input int k);
        logic [15:0] got;
        logic [15:0] want;
        int          base;
        base      = o * `OBJ_WORDS_PER_ENTRY;
        test_name = $sformatf("run_offset_obj%0d", o);
        want      = 16'(shadow[base + `OBJ_W_OFFSET] + k * shadow[base + `OBJ_W_PITCH]);
        host_access(1'b0, `OBJ_TBL_AW'(base + `OBJ_W_RUN), 16'h0, got);
        assert (got == want) else abort_run($sformatf(
            "mismatch %s expected %h actual %h", test_name, want, got));
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        hstart     = 1'b0;
        vrender    = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        rom_data   = '0;
        rng        = 32'h1057_18c3;
        test_name  = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (host_ack === 1'b0 && buf_we === 1'b0)
            else abort_run("host_ack or buf_we is not low after reset");
        test_name = "table_rw";
        table_rw();
        setup_objects();
        run_line(0, 1'b0);
        for (int l = 20; l < 28; l++) begin
            run_line(l, l == 23);     // Host traffic on one busy line
        end
        run_line(230, 1'b0);          // Below the visible area
        check_run(0, 8);
        check_run(1, 6);
        check_run(2, 6);
        check_run(7, 9);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: source/obj_top.sv
// Object line engine top; sprite ROM and line buffer live outside and host accesses follow four-phase req/ack
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hstart,
    input  logic [8:0]             vrender,
    input  logic                   host_req,
    output logic                   host_ack,
    input  logic                   host_we,
    input  logic [`OBJ_TBL_AW-1:0] host_addr,
    input  logic [15:0]            host_wdata,
    output logic [15:0]            host_rdata,
    output logic [17:0]            rom_addr,
    input  logic [15:0]            rom_data,
    output logic                   buf_we,
    output logic [8:0]             buf_addr,
    output logic [11:0]            buf_data
);

    obj_tbl_if host_port ();
    obj_tbl_if scan_port ();

    obj_pkg::obj_cmd_t cmd;      // Scanner to drawer
    logic              cmd_req;
    logic              cmd_ack;

    // Host pins onto the table port
    assign host_port.req   = host_req;
    assign host_port.we    = host_we;
    assign host_port.addr  = host_addr;
    assign host_port.wdata = host_wdata;
    assign host_ack        = host_port.ack;
    assign host_rdata      = host_port.rdata;

    obj_table i_table (
        .clk  (clk),
        .rst  (rst),
        .host (host_port),
        .scan (scan_port)
    );

    obj_scan i_scan (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .vrender (vrender),
        .tbl     (scan_port),
        .cmd     (cmd),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack)
    );

    obj_draw i_draw (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data)
    );

endmodule

// File: source/obj_draw.sv
// One object line per command; ROM data must follow rom_addr by one clock and x wraps at 512
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_draw (
    input  logic               clk,
    input  logic               rst,
    input  obj_pkg::obj_cmd_t  cmd,
    input  logic               cmd_req,
    output logic               cmd_ack,
    output logic [17:0]        rom_addr,
    input  logic [15:0]        rom_data,
    output logic               buf_we,
    output logic [8:0]         buf_addr,
    output logic [11:0]        buf_data
);

    localparam int NWORD = `OBJ_DRAW_WORDS;
    localparam int NPIX  = NWORD * 4;
    localparam int KW    = $clog2(NWORD);
    localparam int PW    = $clog2(NPIX);

    obj_pkg::obj_cmd_t cur;        // Latched command
    logic              take;
    logic              busy;
    logic              fetching;   // Issuing ROM words
    logic [KW-1:0]     fk;         // Word being issued
    logic              cap_v;      // rom_data valid now
    logic [KW-1:0]     cap_k;      // Word index of rom_data
    logic [3:0]        pix [NPIX]; // Pixels in object order
    logic [3:0]        nib [4];
    logic [NPIX-1:0]   mask;       // Opaque pixels still to write
    logic [NPIX-1:0]   set_bits;
    logic [NPIX-1:0]   clr_bits;
    logic [NPIX-1:0]   mask_next;
    logic              pick_v;
    logic [PW-1:0]     pick_n;
    logic [14:0]       word_ofs;

    assign take = !busy && cmd_req && !cmd_ack;  // Idle only

    // Flip walks the ROM downwards
    assign word_ofs = cur.offset.f.flip ? cur.offset.f.word - 15'(fk)
                                        : cur.offset.f.word + 15'(fk);
    assign rom_addr = {cur.bank, word_ofs};

    // Word split, MSB nibble first unless flipped
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            nib[j] = cur.offset.f.flip ? rom_data[4*j +: 4] : rom_data[15-4*j -: 4];
        end
    end

    always_comb begin
        set_bits = '0;
        if (cap_v) begin
            for (int j = 0; j < 4; j++) begin
                if (nib[j] != 4'd0) begin
                    set_bits[4*cap_k + j] = 1'b1;  // Zero is transparent
                end
            end
        end
    end

    // Lowest pending pixel goes next
    always_comb begin
        pick_v = 1'b0;
        pick_n = '0;
        for (int i = NPIX - 1; i >= 0; i--) begin
            if (mask[i]) begin
                pick_v = 1'b1;
                pick_n = PW'(i);
            end
        end
        clr_bits = '0;
        if (pick_v) begin
            clr_bits[pick_n] = 1'b1;
        end
    end

    assign mask_next = (mask & ~clr_bits) | set_bits;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_ack  <= 1'b0;
            busy     <= 1'b0;
            fetching <= 1'b0;
            fk       <= '0;
            cap_v    <= 1'b0;
            mask     <= '0;
            buf_we   <= 1'b0;
        end else begin
            buf_we <= 1'b0;
            cap_v  <= fetching;
            if (cmd_ack && !cmd_req) begin
                cmd_ack <= 1'b0;   // Phase 4
            end
            if (!busy) begin
                if (take) begin
                    cmd_ack  <= 1'b1;
                    busy     <= 1'b1;
                    fetching <= 1'b1;
                    fk       <= '0;
                end
            end else begin
                if (fetching) begin
                    fk <= fk + 1'b1;
                    if (fk == KW'(NWORD - 1)) begin
                        fetching <= 1'b0;
                    end
                end
                mask   <= mask_next;
                buf_we <= pick_v;
                if (!fetching && !cap_v && mask_next == '0) begin
                    busy <= 1'b0;  // Last pixel issued
                end
            end
        end
    end

    // Pixel store and line buffer word
    always_ff @(posedge clk) begin
        if (take) begin
            cur <= cmd;
        end
        cap_k <= fk;
        if (cap_v) begin
            for (int j = 0; j < 4; j++) begin
                pix[4*cap_k + j] <= nib[j];
            end
        end
        if (pick_v) begin
            buf_addr <= cur.xpos + {{(9-PW){1'b0}}, pick_n};  // Wraps mod 512
            buf_data <= {cur.prio, cur.pal, pix[pick_n]};
        end
    end

endmodule

// File: source/obj_scan.sv
// Walks the table once per visible line; hstart during a walk is ignored and offsets wrap mod 2^16
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic                hstart,
    input  logic [8:0]          vrender,
    obj_tbl_if.requester        tbl,
    output obj_pkg::obj_cmd_t   cmd,
    output logic                cmd_req,
    input  logic                cmd_ack
);

    localparam int AW  = `OBJ_TBL_AW;
    localparam int WIW = $clog2(`OBJ_WORDS_PER_ENTRY);
    localparam int OW  = AW - WIW;

    typedef enum logic [3:0] {
        S_IDLE, S_ZONE, S_XPOS, S_PITCH, S_OFS, S_ATTR, S_WB, S_CMD, S_NEXT
    } state_t;

    state_t         st;
    logic [OW-1:0]  obj;       // Current object
    logic [WIW-1:0] widx;      // Word inside descriptor
    logic           wait_low;  // Waiting for ack to fall
    logic           acc_end;   // Table access fully closed
    logic [15:0]    rd;        // Last table word
    logic [7:0]     line;      // Line being scanned
    logic           first;     // Line equals top
    logic [15:0]    pitch;
    logic [7:0]     zone_top;
    logic [7:0]     zone_bot;
    logic           inzone;

    assign tbl.addr  = {obj, widx};
    assign tbl.wdata = cmd.offset.raw + pitch;  // Two's complement add

    assign acc_end  = wait_low && !tbl.ack;
    assign zone_bot = rd[15:8];
    assign zone_top = rd[7:0];
    assign inzone   = (line >= zone_top) && (zone_bot > line);  // Empty when top not below bottom

    // Walker and table handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= S_IDLE;
            obj      <= '0;
            widx     <= '0;
            tbl.req  <= 1'b0;
            tbl.we   <= 1'b0;
            wait_low <= 1'b0;
            cmd_req  <= 1'b0;
        end else begin
            if (tbl.req && tbl.ack) begin
                tbl.req  <= 1'b0;   // Phase 3
                wait_low <= 1'b1;
            end
            if (acc_end) begin
                wait_low <= 1'b0;
            end
            case (st)
                S_IDLE: if (hstart && vrender <= 9'(`OBJ_LAST_LINE)) begin
                    obj     <= '0;
                    widx    <= WIW'(`OBJ_W_ZONE);
                    tbl.we  <= 1'b0;
                    tbl.req <= 1'b1;
                    st      <= S_ZONE;
                end
                S_ZONE: if (acc_end) begin
                    if (zone_bot >= `OBJ_END_MARK) begin
                        st <= S_IDLE;     // End marker
                    end else if (!inzone) begin
                        st <= S_NEXT;
                    end else begin
                        widx    <= WIW'(`OBJ_W_XPOS);
                        tbl.req <= 1'b1;
                        st      <= S_XPOS;
                    end
                end
                S_XPOS: if (acc_end) begin
                    widx    <= WIW'(`OBJ_W_PITCH);
                    tbl.req <= 1'b1;
                    st      <= S_PITCH;
                end
                S_PITCH: if (acc_end) begin
                    widx    <= first ? WIW'(`OBJ_W_OFFSET) : WIW'(`OBJ_W_RUN);
                    tbl.req <= 1'b1;
                    st      <= S_OFS;
                end
                S_OFS: if (acc_end) begin
                    widx    <= WIW'(`OBJ_W_ATTR);
                    tbl.req <= 1'b1;
                    st      <= S_ATTR;
                end
                S_ATTR: if (acc_end) begin
                    widx    <= WIW'(`OBJ_W_RUN);  // Write back next offset
                    tbl.we  <= 1'b1;
                    tbl.req <= 1'b1;
                    st      <= S_WB;
                end
                S_WB: if (acc_end) begin
                    tbl.we <= 1'b0;
                    st     <= S_CMD;
                end
                S_CMD: begin
                    if (!cmd_req) begin
                        if (!cmd_ack) begin
                            cmd_req <= 1'b1;  // Previous ack gone
                        end
                    end else if (cmd_ack) begin
                        cmd_req <= 1'b0;      // Drawer latched it
                        st      <= S_NEXT;
                    end
                end
                S_NEXT: begin
                    if (obj == '1) begin
                        st <= S_IDLE;         // Past object 255
                    end else begin
                        obj     <= obj + 1'b1;
                        widx    <= WIW'(`OBJ_W_ZONE);
                        tbl.we  <= 1'b0;
                        tbl.req <= 1'b1;
                        st      <= S_ZONE;
                    end
                end
                default: st <= S_IDLE;
            endcase
        end
    end

    // Descriptor fields
    always_ff @(posedge clk) begin
        if (tbl.req && tbl.ack) begin
            rd <= tbl.rdata;
        end
        if (st == S_IDLE) begin
            line <= vrender[7:0];
        end
        if (acc_end) begin
            case (st)
                S_ZONE:  first <= line == zone_top;
                S_XPOS:  cmd.xpos <= rd[8:0];
                S_PITCH: pitch <= rd;
                S_OFS:   cmd.offset.raw <= rd;  // OFFSET or RUN
                S_ATTR: begin
                    cmd.pal  <= rd[13:8];
                    cmd.bank <= rd[6:4];
                    cmd.prio <= rd[1:0];
                end
                default: ;
            endcase
        end
    end

endmodule

// File: source/obj_table.sv
// Two-port object table; one access per grant and a port must drop req before its next access
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_table (
    input logic        clk,
    input logic        rst,
    obj_tbl_if.arbiter host,
    obj_tbl_if.arbiter scan
);

    localparam int AW = `OBJ_TBL_AW;

    logic [15:0]   mem [2**AW];  // Descriptor words
    logic          busy;         // A grant is open
    logic          gnt;          // 1 when scan holds the grant
    logic          prio;         // Tie winner, 1 for scan
    logic          sel;
    logic          take;
    logic [AW-1:0] addr_g;
    logic          we_g;
    logic [15:0]   wdata_g;

    // Round robin only matters on a tie
    assign sel  = (host.req && scan.req) ? prio : scan.req;
    assign take = !busy && (host.req || scan.req);

    // Granted request fields
    assign addr_g  = sel ? scan.addr  : host.addr;
    assign we_g    = sel ? scan.we    : host.we;
    assign wdata_g = sel ? scan.wdata : host.wdata;

    // Grant and per-port ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            gnt      <= 1'b0;
            prio     <= 1'b0;
            host.ack <= 1'b0;
            scan.ack <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
            gnt  <= sel;
            prio <= !sel;           // Loser wins the next tie
            if (sel) begin
                scan.ack <= 1'b1;
            end else begin
                host.ack <= 1'b1;
            end
        end else if (busy && gnt && !scan.req) begin
            scan.ack <= 1'b0;       // Phase 4 for scan
            busy     <= 1'b0;
        end else if (busy && !gnt && !host.req) begin
            host.ack <= 1'b0;       // Phase 4 for host
            busy     <= 1'b0;
        end
    end

    // Single RAM cycle in the grant cycle
    always_ff @(posedge clk) begin
        if (take) begin
            if (we_g) begin
                mem[addr_g] <= wdata_g;
            end
            if (sel) begin
                scan.rdata <= mem[addr_g];
            end else begin
                host.rdata <= mem[addr_g];
            end
        end
    end

endmodule

// File: source/obj_tbl_if.sv
// One requester port into the object table; four-phase req/ack with fields held while req is high
`timescale 1ns/1ps
`include "obj_settings.svh"

interface obj_tbl_if;

    logic                   req;    // Held until ack
    logic                   ack;    // Rises with rdata valid
    logic                   we;
    logic [`OBJ_TBL_AW-1:0] addr;
    logic [15:0]            wdata;
    logic [15:0]            rdata;  // Old word on writes

    // Scanner or host side
    modport requester (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    // Table side
    modport arbiter (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

// File: source/obj_pkg.sv
// Types only; the offset MSB doubles as flip and leaves a 15-bit ROM word offset
package obj_pkg;

    // Flip view of an offset word
    typedef struct packed {
        logic        flip;   // Reverse word and pixel order
        logic [14:0] word;   // ROM word offset inside bank
    } obj_ofs_fields_t;

    // Raw view for pitch arithmetic
    typedef union packed {
        logic [15:0]     raw;
        obj_ofs_fields_t f;
    } obj_offset_u;

    // One object line handed to the drawer
    typedef struct packed {
        logic [8:0]  xpos;     // Left pixel
        obj_offset_u offset;   // Offset for this line
        logic [2:0]  bank;     // ROM bank
        logic [1:0]  prio;
        logic [5:0]  pal;
    } obj_cmd_t;

endpackage

// File: source/obj_settings.svh
// Table address width must equal object index bits plus word index bits; draw width is a power of two
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// Table geometry
`define OBJ_WORDS_PER_ENTRY 8
`define OBJ_TBL_AW          11     // 256 objects of 8 words

// Line and table limits
`define OBJ_LAST_LINE       223    // Last rendered line
`define OBJ_END_MARK        8'hF0  // Bottom at or above ends the table

// Drawer width in ROM words
`define OBJ_DRAW_WORDS      4      // 4 pixels per word

// Descriptor word indices
`define OBJ_W_ZONE          0      // Bottom high byte and top low byte
`define OBJ_W_XPOS          1
`define OBJ_W_PITCH         2      // Signed
`define OBJ_W_OFFSET        3
`define OBJ_W_ATTR          4      // Palette 13:8 bank 6:4 priority 1:0
`define OBJ_W_RUN           6      // Running offset

`endif
